// ==== hdl/mips_control_pkg.sv ====
`default_nettype none

package mips_control_pkg;

    // Step count from the external phase counter
    typedef logic [2:0] phase_t;

    // Instruction fields as seen by the decoder
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Supported opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0A;
    localparam opcode_t OP_ANDI  = 6'h0C;
    localparam opcode_t OP_ORI   = 6'h0D;
    localparam opcode_t OP_LUI   = 6'h0F;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;

    // Supported R-type funct codes
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2A;

    // FSM states, code 8 is unused
    typedef enum logic [3:0] {
        IDLE              = 4'd0,
        FETCH             = 4'd1,
        DECODE            = 4'd2,
        EXECUTE           = 4'd3,
        WRITE_BACK        = 4'd4,
        STORE             = 4'd5,
        LOAD              = 4'd6,
        EFFECTIVE_ADDR    = 4'd7,
        BRANCH_ADDR       = 4'd9,
        BRANCH_EQ_COMPARE = 4'd10,
        EXEC_JUMP         = 4'd11,
        UNDEFINED         = 4'd12,
        BRANCH_NE_COMPARE = 4'd13,
        UPDATE_PC         = 4'd14,
        RETIRE            = 4'd15
    } ctrl_state_t;

    // ALU operation codes as the datapath ALU expects them
    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_t;

    // Operand B mux select
    typedef enum logic [1:0] {
        SRCB_REG         = 2'd0,
        SRCB_FOUR        = 2'd1,
        SRCB_IMM         = 2'd2,
        SRCB_IMM_SHIFTED = 2'd3
    } src_b_sel_t;

    // Jump target kind for the datapath
    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_J    = 2'd1,
        JUMP_REG  = 2'd2
    } jump_kind_t;

    // Path taken out of DECODE
    typedef enum logic [2:0] {
        ROUTE_ALU       = 3'd0,
        ROUTE_MEM       = 3'd1,
        ROUTE_BRANCH    = 3'd2,
        ROUTE_JUMP      = 3'd3,
        ROUTE_UNDEFINED = 3'd4
    } exec_route_t;

    // Everything the FSM and control decoder need from one instruction
    typedef struct packed {
        exec_route_t route;
        jump_kind_t  jump_kind;
        logic        is_load;
        logic        branch_ne;
        logic        dest_is_rd;
        alu_op_t     alu_op;
        src_b_sel_t  src_b;
    } decoded_instr_t;

    // Datapath control word, first field is the MSB
    typedef struct packed {
        logic       iord;
        logic       mem_write;
        logic       ir_write;
        logic       reg_dst;
        logic       mem_to_reg;
        logic       pc_write;
        logic       branch;
        logic       pc_src;
        alu_op_t    alu_control;
        src_b_sel_t alu_src_b;
        logic       alu_src_a;
        logic       reg_write;
        logic       mem_select;
        logic       data_write;
        logic       rdx_en;
        logic       alu_result_en;
        logic       pc_en;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== hdl/instruction_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instruction_decoder
(
    input  mips_control_pkg::opcode_t        opcode,
    input  mips_control_pkg::funct_t         funct,
    output mips_control_pkg::decoded_instr_t decoded
);

    // ALU operation for arithmetic R-type funct codes
    mips_control_pkg::alu_op_t rtype_op;
    // Funct is one of the supported arithmetic codes
    logic                      rtype_ok;

    always_comb
    begin
        rtype_op = mips_control_pkg::ALU_AND;
        rtype_ok = 1'b1;
        case (funct)
            mips_control_pkg::FN_ADD: rtype_op = mips_control_pkg::ALU_ADD;
            mips_control_pkg::FN_SUB: rtype_op = mips_control_pkg::ALU_SUB;
            mips_control_pkg::FN_AND: rtype_op = mips_control_pkg::ALU_AND;
            mips_control_pkg::FN_OR:  rtype_op = mips_control_pkg::ALU_OR;
            mips_control_pkg::FN_SLT: rtype_op = mips_control_pkg::ALU_SLT;
            // jr and unknown codes are handled by the opcode lookup
            default:                  rtype_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        // Anything not matched below is undefined with all other fields zero
        decoded = '0;
        decoded.route = mips_control_pkg::ROUTE_UNDEFINED;
        case (opcode)
            mips_control_pkg::OP_RTYPE:
            begin
                if (funct == mips_control_pkg::FN_JR)
                begin
                    decoded.route     = mips_control_pkg::ROUTE_JUMP;
                    decoded.jump_kind = mips_control_pkg::JUMP_REG;
                end
                else if (rtype_ok)
                begin
                    // Register operand, result goes to rd
                    decoded.route      = mips_control_pkg::ROUTE_ALU;
                    decoded.dest_is_rd = 1'b1;
                    decoded.alu_op     = rtype_op;
                    decoded.src_b      = mips_control_pkg::SRCB_REG;
                end
            end
            mips_control_pkg::OP_ADDI, mips_control_pkg::OP_SLTI,
            mips_control_pkg::OP_ANDI, mips_control_pkg::OP_ORI,
            mips_control_pkg::OP_LUI:
            begin
                // Immediate operand, result goes to rt
                decoded.route = mips_control_pkg::ROUTE_ALU;
                decoded.src_b = mips_control_pkg::SRCB_IMM;
                case (opcode)
                    mips_control_pkg::OP_SLTI: decoded.alu_op = mips_control_pkg::ALU_SLT;
                    mips_control_pkg::OP_ANDI: decoded.alu_op = mips_control_pkg::ALU_AND;
                    mips_control_pkg::OP_ORI:  decoded.alu_op = mips_control_pkg::ALU_OR;
                    mips_control_pkg::OP_LUI:  decoded.alu_op = mips_control_pkg::ALU_LUI;
                    default:                   decoded.alu_op = mips_control_pkg::ALU_ADD;
                endcase
            end
            mips_control_pkg::OP_LW, mips_control_pkg::OP_SW:
            begin
                // Base plus offset address
                decoded.route   = mips_control_pkg::ROUTE_MEM;
                decoded.alu_op  = mips_control_pkg::ALU_ADD;
                decoded.src_b   = mips_control_pkg::SRCB_IMM;
                decoded.is_load = (opcode == mips_control_pkg::OP_LW);
            end
            mips_control_pkg::OP_BEQ, mips_control_pkg::OP_BNE:
            begin
                decoded.route     = mips_control_pkg::ROUTE_BRANCH;
                decoded.alu_op    = mips_control_pkg::ALU_SUB;
                decoded.branch_ne = (opcode == mips_control_pkg::OP_BNE);
            end
            mips_control_pkg::OP_J:
            begin
                decoded.route     = mips_control_pkg::ROUTE_JUMP;
                decoded.jump_kind = mips_control_pkg::JUMP_J;
                decoded.alu_op    = mips_control_pkg::ALU_ADD;
            end
            default:
            begin
                decoded.route = mips_control_pkg::ROUTE_UNDEFINED;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/control_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_sequencer
(
    input  logic                             clk,
    input  logic                             reset,
    input  mips_control_pkg::phase_t         phase,
    input  mips_control_pkg::decoded_instr_t decoded,
    output mips_control_pkg::ctrl_state_t    state
);

    mips_control_pkg::ctrl_state_t next_state;

    // Each state holds until the phase counter reaches its advancing value
    always_comb
    begin
        next_state = state;
        case (state)
            mips_control_pkg::IDLE:
            begin
                if (phase == 3'd1)
                    next_state = mips_control_pkg::FETCH;
            end
            mips_control_pkg::FETCH:
            begin
                if (phase == 3'd2)
                    next_state = mips_control_pkg::DECODE;
            end
            mips_control_pkg::DECODE:
            begin
                // Route chosen by the instruction decoder
                if (phase == 3'd3)
                begin
                    case (decoded.route)
                        mips_control_pkg::ROUTE_ALU:
                            next_state = mips_control_pkg::EXECUTE;
                        mips_control_pkg::ROUTE_MEM:
                            next_state = mips_control_pkg::EFFECTIVE_ADDR;
                        mips_control_pkg::ROUTE_BRANCH:
                            next_state = mips_control_pkg::BRANCH_ADDR;
                        mips_control_pkg::ROUTE_JUMP:
                            next_state = mips_control_pkg::EXEC_JUMP;
                        default:
                            next_state = mips_control_pkg::UNDEFINED;
                    endcase
                end
            end
            mips_control_pkg::EXECUTE:
            begin
                if (phase == 3'd4)
                    next_state = mips_control_pkg::WRITE_BACK;
            end
            mips_control_pkg::EFFECTIVE_ADDR:
            begin
                // lw reads memory, sw writes it
                if (phase == 3'd4)
                    next_state = decoded.is_load ? mips_control_pkg::LOAD
                                                 : mips_control_pkg::STORE;
            end
            mips_control_pkg::BRANCH_ADDR:
            begin
                if (phase == 3'd4)
                    next_state = decoded.branch_ne ? mips_control_pkg::BRANCH_NE_COMPARE
                                                   : mips_control_pkg::BRANCH_EQ_COMPARE;
            end
            mips_control_pkg::EXEC_JUMP:
            begin
                if (phase == 3'd4)
                    next_state = mips_control_pkg::UPDATE_PC;
            end
            mips_control_pkg::WRITE_BACK, mips_control_pkg::STORE,
            mips_control_pkg::LOAD, mips_control_pkg::BRANCH_EQ_COMPARE,
            mips_control_pkg::BRANCH_NE_COMPARE, mips_control_pkg::UPDATE_PC:
            begin
                // Last active step of every path
                if (phase == 3'd5)
                    next_state = mips_control_pkg::RETIRE;
            end
            mips_control_pkg::RETIRE:
            begin
                // Next instruction starts here
                if (phase == 3'd1)
                    next_state = mips_control_pkg::FETCH;
            end
            mips_control_pkg::UNDEFINED:
            begin
                // Drop back without waiting for the phase
                next_state = mips_control_pkg::IDLE;
            end
            default:
            begin
                next_state = mips_control_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            state <= mips_control_pkg::IDLE;
        else
            state <= next_state;
    end

endmodule

`default_nettype wire

// ==== hdl/control_signal_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_signal_decoder
(
    input  mips_control_pkg::ctrl_state_t    state,
    input  mips_control_pkg::decoded_instr_t decoded,
    input  logic                             zero,
    output mips_control_pkg::ctrl_word_t     ctrl
);

    always_comb
    begin
        // Every field inactive unless the state asks for it
        ctrl = '0;
        case (state)
            mips_control_pkg::FETCH:
            begin
                // Load IR and compute PC + 4
                ctrl.ir_write    = 1'b1;
                ctrl.alu_src_b   = mips_control_pkg::SRCB_FOUR;
                ctrl.alu_control = mips_control_pkg::ALU_ADD;
                ctrl.pc_write    = 1'b1;
            end
            mips_control_pkg::DECODE:
            begin
                // Latch register operands and set up the ALU early
                ctrl.reg_dst     = decoded.dest_is_rd;
                ctrl.rdx_en      = 1'b1;
                ctrl.alu_src_b   = decoded.src_b;
                ctrl.alu_control = decoded.alu_op;
                ctrl.alu_src_a   = 1'b1;
            end
            mips_control_pkg::EXECUTE, mips_control_pkg::EXEC_JUMP:
            begin
                ctrl.reg_dst       = decoded.dest_is_rd;
                ctrl.alu_src_b     = decoded.src_b;
                ctrl.alu_control   = decoded.alu_op;
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_result_en = 1'b1;
                // Jumps also load the new target into the PC
                ctrl.pc_write      = (state == mips_control_pkg::EXEC_JUMP);
            end
            mips_control_pkg::UPDATE_PC:
            begin
                // Refetch from the jump target
                ctrl.ir_write    = 1'b1;
                ctrl.alu_src_b   = mips_control_pkg::SRCB_FOUR;
                ctrl.alu_control = mips_control_pkg::ALU_ADD;
            end
            mips_control_pkg::WRITE_BACK:
            begin
                // ALU result into the register file
                ctrl.reg_dst       = decoded.dest_is_rd;
                ctrl.reg_write     = 1'b1;
                ctrl.alu_control   = decoded.alu_op;
                ctrl.alu_result_en = 1'b1;
            end
            mips_control_pkg::EFFECTIVE_ADDR:
            begin
                // Base register plus immediate offset
                ctrl.rdx_en        = 1'b1;
                ctrl.alu_src_b     = mips_control_pkg::SRCB_IMM;
                ctrl.alu_control   = decoded.alu_op;
                ctrl.alu_src_a     = 1'b1;
                ctrl.alu_result_en = 1'b1;
            end
            mips_control_pkg::STORE:
            begin
                // Data RAM write at the computed address
                ctrl.iord       = 1'b1;
                ctrl.mem_write  = 1'b1;
                ctrl.mem_select = 1'b1;
            end
            mips_control_pkg::LOAD:
            begin
                // Data RAM read straight into the register file
                ctrl.iord       = 1'b1;
                ctrl.mem_select = 1'b1;
                ctrl.data_write = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_dst    = decoded.dest_is_rd;
                ctrl.reg_write  = 1'b1;
            end
            mips_control_pkg::RETIRE:
            begin
                // Loads get one more write so the data register value lands
                ctrl.iord       = 1'b1;
                ctrl.mem_to_reg = decoded.is_load;
                ctrl.reg_write  = decoded.is_load;
            end
            mips_control_pkg::BRANCH_ADDR:
            begin
                // PC + (imm << 2) into the ALU result register
                ctrl.alu_src_b     = mips_control_pkg::SRCB_IMM_SHIFTED;
                ctrl.alu_control   = mips_control_pkg::ALU_ADD;
                ctrl.alu_result_en = 1'b1;
            end
            mips_control_pkg::BRANCH_EQ_COMPARE, mips_control_pkg::BRANCH_NE_COMPARE:
            begin
                // Subtract the operands and take the target on the zero flag
                ctrl.rdx_en      = 1'b1;
                ctrl.alu_control = mips_control_pkg::ALU_SUB;
                ctrl.alu_src_a   = 1'b1;
                ctrl.pc_src      = 1'b1;
                if (state == mips_control_pkg::BRANCH_NE_COMPARE)
                    ctrl.branch = ~zero;
                else
                    ctrl.branch = zero;
            end
            default:
            begin
                // IDLE and UNDEFINED keep the datapath still
                ctrl = '0;
            end
        endcase
        // PC register loads on an unconditional write or a taken branch
        ctrl.pc_en = ctrl.branch | ctrl.pc_write;
    end

endmodule

`default_nettype wire

// ==== hdl/mips_control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_control_unit
(
    input  logic                         clk,
    input  logic                         reset,
    input  mips_control_pkg::phase_t     phase,
    input  mips_control_pkg::opcode_t    opcode,
    input  mips_control_pkg::funct_t     funct,
    input  logic                         zero,
    output mips_control_pkg::ctrl_word_t ctrl,
    output mips_control_pkg::jump_kind_t jump_kind
);

    // Decoded view of the current instruction, shared by FSM and control decode
    mips_control_pkg::decoded_instr_t decoded;
    mips_control_pkg::ctrl_state_t    state;

    instruction_decoder u_instruction_decoder
    (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    control_sequencer u_control_sequencer
    (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .decoded (decoded),
        .state   (state)
    );

    control_signal_decoder u_control_signal_decoder
    (
        .state   (state),
        .decoded (decoded),
        .zero    (zero),
        .ctrl    (ctrl)
    );

    // Datapath picks the jump target from this in every state
    assign jump_kind = decoded.jump_kind;

endmodule

`default_nettype wire

// ==== test/tb_mips_control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mips_control_unit;

    // One stimulus vector with inputs first and the outputs expected a cycle later
    typedef struct packed {
        mips_control_pkg::phase_t     phase;
        mips_control_pkg::opcode_t    opcode;
        mips_control_pkg::funct_t     funct;
        logic                         zero;
        mips_control_pkg::ctrl_word_t exp_ctrl;
        logic [1:0]                   exp_jump;
    } stim_line_t;

    logic                         clk;
    logic                         reset;
    mips_control_pkg::phase_t     phase;
    mips_control_pkg::opcode_t    opcode;
    mips_control_pkg::funct_t     funct;
    logic                         zero;
    mips_control_pkg::ctrl_word_t ctrl;
    mips_control_pkg::jump_kind_t jump_kind;

    stim_line_t stim_q[$];
    int         checks       = 0;
    int         mismatches   = 0;
    int         other_errors = 0;
    int         cycle_count  = 0;
    int         cycle_limit  = 0;

    mips_control_unit DUT
    (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .opcode    (opcode),
        .funct     (funct),
        .zero      (zero),
        .ctrl      (ctrl),
        .jump_kind (jump_kind)
    );

    // 10 ns clock
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit follows the vector count plus a margin for reset
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("ERROR: timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Reads all vectors up front and skips lines starting with #
    task automatic load_stimulus();
        int                           fd;
        int                           rc;
        int                           line_no;
        string                        text;
        mips_control_pkg::phase_t     ph;
        mips_control_pkg::opcode_t    op;
        mips_control_pkg::funct_t     fn;
        logic                         z;
        logic [20:0]                  cw;
        logic [1:0]                   jk;
        stim_line_t                   entry;
        fd = $fopen("test/control_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open stimulus file test/control_stimulus.txt");
            other_errors++;
            return;
        end
        line_no = 0;
        while ($fgets(text, fd) != 0)
        begin
            line_no++;
            if (text.len() == 0 || text[0] == "#" || text[0] == "\n")
                continue;
            rc = $sscanf(text, "%h %h %h %h %h %h", ph, op, fn, z, cw, jk);
            if (rc != 6)
            begin
                $display("ERROR: stimulus line %0d does not hold six hex fields", line_no);
                other_errors++;
            end
            else
            begin
                entry.phase    = ph;
                entry.opcode   = op;
                entry.funct    = fn;
                entry.zero     = z;
                entry.exp_ctrl = cw;
                entry.exp_jump = jk;
                stim_q.push_back(entry);
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0)
        begin
            $display("ERROR: stimulus file holds no vectors");
            other_errors++;
        end
    endtask

    // Inputs change on the falling edge away from the sampling edge
    task automatic apply_inputs(input int index);
        phase  = stim_q[index].phase;
        opcode = stim_q[index].opcode;
        funct  = stim_q[index].funct;
        zero   = stim_q[index].zero;
    endtask

    // Outputs have settled by the falling edge after the state update
    task automatic check_outputs(input int index);
        stim_line_t entry;
        entry = stim_q[index];
        checks++;
        if (ctrl !== entry.exp_ctrl)
        begin
            $display("MISMATCH at %0t: vector %0d ctrl expected %h got %h (diff %h)",
                     $time, index + 1, entry.exp_ctrl, ctrl, ctrl ^ entry.exp_ctrl);
            mismatches++;
        end
        if (jump_kind !== entry.exp_jump)
        begin
            $display("MISMATCH at %0t: vector %0d jump_kind expected %h got %h",
                     $time, index + 1, entry.exp_jump, jump_kind);
            mismatches++;
        end
    endtask

    initial
    begin
        reset  = 1'b0;
        phase  = '0;
        opcode = '0;
        funct  = '0;
        zero   = 1'b0;
        load_stimulus();
        cycle_limit = stim_q.size() + 20;
        // Reset held for three clock cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < stim_q.size(); i++)
        begin
            apply_inputs(i);
            @(negedge clk);
            check_outputs(i);
        end
        $display("Checks: %0d  mismatches: %0d  other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/control_stimulus.txt ====
# Columns in hex: phase opcode funct zero expected_ctrl expected_jump_kind
# Expected values are the outputs one cycle after the inputs of the same line
0 00 20 0 000000 0
0 00 20 0 000000 0
1 00 20 0 048481 0
1 00 20 0 048481 0
2 00 20 0 020444 0
2 00 20 0 020444 0
3 00 20 0 020442 0
4 00 20 0 020422 0
4 00 20 0 020422 0
5 00 20 0 100000 0
5 00 20 0 100000 0
1 0D 00 0 048481 0
2 0D 00 0 000744 0
3 0D 00 0 000742 0
4 0D 00 0 000622 0
5 0D 00 0 100000 0
1 23 00 0 048481 0
2 23 00 0 000544 0
3 23 00 0 000546 0
3 23 00 0 000546 0
4 23 00 0 110038 0
5 23 00 0 110020 0
5 23 00 0 110020 0
1 2B 00 0 048481 0
2 2B 00 0 000544 0
3 2B 00 0 000546 0
4 2B 00 0 180010 0
5 2B 00 0 100000 0
1 04 00 1 048481 0
2 04 00 1 000244 0
3 04 00 1 000582 0
4 04 00 1 006245 0
4 04 00 0 002244 0
5 04 00 0 100000 0
1 04 00 0 048481 0
2 04 00 0 000244 0
3 04 00 0 000582 0
4 04 00 0 002244 0
5 04 00 0 100000 0
1 05 00 1 048481 0
2 05 00 1 000244 0
3 05 00 1 000582 0
4 05 00 1 002244 0
4 05 00 0 006245 0
5 05 00 0 100000 0
1 02 00 0 048481 1
2 02 00 0 000444 1
3 02 00 0 008443 1
4 02 00 0 040480 1
5 02 00 0 100000 1
1 00 08 0 048481 2
2 00 08 0 000044 2
3 00 08 0 008043 2
4 00 08 0 040480 2
5 00 08 0 100000 2
1 3F 00 0 048481 0
2 3F 00 0 000044 0
3 3F 00 0 000000 0
3 3F 00 0 000000 0
1 3F 00 0 048481 0

// ==== mips_control_unit.f ====
hdl/mips_control_pkg.sv
hdl/instruction_decoder.sv
hdl/control_sequencer.sv
hdl/control_signal_decoder.sv
hdl/mips_control_unit.sv
test/tb_mips_control_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1
then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 --timescale 1ns/100ps \
    --top-module tb_mips_control_unit -f mips_control_unit.f
if [ $? -ne 0 ]
then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_mips_control_unit 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]
then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -Fxq "Simulation finished: PASS"
then
    exit 0
fi
exit 1
